// File: source/vdecode_macros.svh
// vector decode widths, lane count and OP-V instruction encodings
`ifndef VDECODE_MACROS_SVH
`define VDECODE_MACROS_SVH

// datapath and index widths
`define XLEN      32
`define VREG_W    5
`define OFFSET_W  8
`define LANES     2

// major opcode of all vector instructions
`define OPC_OPV   7'b1010111

// funct3 operand categories
`define F3_IVV    3'b000
`define F3_MVV    3'b010
`define F3_IVI    3'b011
`define F3_IVX    3'b100
`define F3_MVX    3'b110
`define F3_CFG    3'b111

// funct6 codes, slide codes are shared with vslide1up/vslide1down under MVX
`define F6_ADD        6'b000000
`define F6_SUB        6'b000010
`define F6_RGATHER    6'b001100
`define F6_SLIDEUP    6'b001110
`define F6_SLIDEDOWN  6'b001111
`define F6_WADDU      6'b110000
`define F6_NSRL       6'b101100

`endif

// File: source/vdecode_pkg.sv
// vector decode types shared by the control, offset, operand and register blocks
`include "vdecode_macros.svh"

package vdecode_pkg;

  // vsew field of vtype, bits 4:3
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // OP-V arithmetic encoding
  typedef struct packed {
    logic [5:0]         funct6;
    logic               vm;
    logic [`VREG_W-1:0] vs2;
    logic [`VREG_W-1:0] vs1;
    logic [2:0]         funct3;
    logic [`VREG_W-1:0] vd;
    logic [6:0]         opcode;
  } varith_t;

  // vsetvli / vsetivli encoding, vtypei[10] is bit 30
  typedef struct packed {
    logic               sel_ivli;
    logic [10:0]        vtypei;
    logic [`VREG_W-1:0] rs1_uimm;
    logic [2:0]         funct3;
    logic [`VREG_W-1:0] rd;
    logic [6:0]         opcode;
  } vcfg_t;

  typedef union packed {
    varith_t arith;
    vcfg_t   cfg;
  } vinstr_u;

  typedef struct packed {
    logic [`XLEN-1:0] vtype;
    logic [`XLEN-1:0] vl;
    logic [`XLEN-1:0] vstart;
  } csr_state_t;

  typedef enum logic {
    VS1_NORMAL,
    VS1_ZERO
  } vs1_src_t;

  typedef enum logic [2:0] {
    VS2_NORMAL,
    VS2_IDX_PLUS_RS1,
    VS2_IDX_PLUS_UIMM,
    VS2_IDX_PLUS_1,
    VS2_IDX_MINUS_1,
    VS2_VS1,
    VS2_RS1,
    VS2_UIMM
  } vs2_src_t;

  typedef enum logic [1:0] {
    VD_NORMAL,
    VD_IDX_PLUS_RS1,
    VD_IDX_PLUS_UIMM
  } vd_src_t;

  // operations handed to execute
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_MOVE,
    ALU_SRL
  } aluop_t;

  typedef struct packed {
    aluop_t             aluop;
    vs1_src_t           vs1_src;
    vs2_src_t           vs2_src;
    vd_src_t            vd_src;
    logic               wen;
    logic               vm;
    logic               widen;
    logic               narrow;
    logic               cfg;
    logic               illegal;
    logic               imm_signed;
    logic [4:0]         imm5;
    logic [`VREG_W-1:0] vs1;
    logic [`VREG_W-1:0] vs2;
    logic [`VREG_W-1:0] vd;
  } vctrl_t;

  typedef struct packed {
    logic [`OFFSET_W-1:0] offset;
    logic                 active;
    logic                 done;
  } elem_pos_t;

  typedef struct packed {
    logic [`LANES-1:0][`OFFSET_W-1:0] vs1;
    logic [`LANES-1:0][`OFFSET_W-1:0] vs2;
    logic [`LANES-1:0][`OFFSET_W-1:0] vd;
  } lane_offs_t;

  typedef struct packed {
    logic [`VREG_W-1:0]               vs1;
    logic [`VREG_W-1:0]               vs2;
    logic [`VREG_W-1:0]               vs3;
    logic [`LANES-1:0][`OFFSET_W-1:0] vs1_off;
    logic [`LANES-1:0][`OFFSET_W-1:0] vs2_off;
    logic [`LANES-1:0][`OFFSET_W-1:0] vs3_off;
    sew_t                             vs2_sew;
  } rf_read_req_t;

  typedef struct packed {
    logic [`LANES-1:0][`XLEN-1:0] vs1_data;
    logic [`LANES-1:0][`XLEN-1:0] vs2_data;
    logic [`LANES-1:0][`XLEN-1:0] vs3_data;
    logic [`LANES-1:0]            v0_mask;
  } rf_read_rsp_t;

  typedef struct packed {
    logic                         active;
    logic [`LANES-1:0]            wen;
    logic [`OFFSET_W-1:0]         woffset0;
    logic [`OFFSET_W-1:0]         woffset1;
    logic [`LANES-1:0][`XLEN-1:0] vs1_lanes;
    logic [`LANES-1:0][`XLEN-1:0] vs2_lanes;
    logic [`LANES-1:0][`XLEN-1:0] vs3_lanes;
    logic [`XLEN-1:0]             imm;
    logic [`XLEN-1:0]             xs1;
    logic [`VREG_W-1:0]           vd;
    aluop_t                       aluop;
    sew_t                         sew;
    sew_t                         eew;
    logic [`XLEN-1:0]             vl;
    logic                         is_masked;
    logic                         cfg_valid;
    logic [`XLEN-1:0]             next_vtype;
    logic [`XLEN-1:0]             next_avl;
    logic                         illegal;
  } de_t;

endpackage

// File: source/vcontrol_unit.sv
// vector control unit, maps an OP-V word onto the decode control word
`timescale 1ns/1ns
`include "vdecode_macros.svh"

module vcontrol_unit (
  input  vdecode_pkg::vinstr_u instr,
  output vdecode_pkg::vctrl_t  ctrl
);

  logic       legal;
  logic       is_vv;
  logic       is_vx;
  logic [2:0] funct3;
  logic [5:0] funct6;

  assign funct3 = instr.arith.funct3;
  assign funct6 = instr.arith.funct6;
  assign is_vv  = (funct3 == `F3_IVV) || (funct3 == `F3_MVV);
  assign is_vx  = (funct3 == `F3_IVX) || (funct3 == `F3_MVX);

  always_comb begin
    ctrl         = '0;
    legal        = 1'b1;
    ctrl.vs1     = instr.arith.vs1;
    ctrl.vs2     = instr.arith.vs2;
    ctrl.vd      = instr.arith.vd;
    ctrl.vm      = instr.arith.vm;
    ctrl.imm5    = instr.arith.vs1;
    ctrl.wen     = 1'b1;
    ctrl.aluop   = vdecode_pkg::ALU_MOVE;
    ctrl.vs2_src = vdecode_pkg::VS2_NORMAL;
    ctrl.vd_src  = vdecode_pkg::VD_NORMAL;
    // vs1 register is only read by the vector-vector forms
    ctrl.vs1_src = is_vv ? vdecode_pkg::VS1_NORMAL : vdecode_pkg::VS1_ZERO;

    if (instr.arith.opcode != `OPC_OPV) begin
      legal = 1'b0;
    end else begin
      case (funct3)
        `F3_CFG: begin
          ctrl.cfg  = 1'b1;
          ctrl.wen  = 1'b0;
          ctrl.vm   = 1'b1;
          ctrl.imm5 = instr.cfg.rs1_uimm;
          ctrl.vd   = instr.cfg.rd;
          // bits 31:30 = 10 is vsetvl, not supported here
          if (instr.cfg.sel_ivli && !instr.cfg.vtypei[10]) begin
            legal = 1'b0;
          end
        end
        `F3_IVV, `F3_IVX, `F3_IVI: begin
          case (funct6)
            `F6_ADD, `F6_SUB: begin
              ctrl.aluop      = (funct6 == `F6_ADD) ? vdecode_pkg::ALU_ADD :
                                                      vdecode_pkg::ALU_SUB;
              ctrl.imm_signed = (funct3 == `F3_IVI);
            end
            `F6_RGATHER: begin
              ctrl.vs2_src = is_vv ? vdecode_pkg::VS2_VS1 :
                             is_vx ? vdecode_pkg::VS2_RS1 : vdecode_pkg::VS2_UIMM;
            end
            `F6_SLIDEUP: begin
              legal       = !is_vv;
              ctrl.vd_src = is_vx ? vdecode_pkg::VD_IDX_PLUS_RS1 :
                                    vdecode_pkg::VD_IDX_PLUS_UIMM;
            end
            `F6_SLIDEDOWN: begin
              legal        = !is_vv;
              ctrl.vs2_src = is_vx ? vdecode_pkg::VS2_IDX_PLUS_RS1 :
                                     vdecode_pkg::VS2_IDX_PLUS_UIMM;
            end
            `F6_NSRL: begin
              ctrl.aluop  = vdecode_pkg::ALU_SRL;
              ctrl.narrow = 1'b1;
            end
            default: legal = 1'b0;
          endcase
        end
        `F3_MVV, `F3_MVX: begin
          case (funct6)
            `F6_WADDU: begin
              ctrl.aluop = vdecode_pkg::ALU_ADD;
              ctrl.widen = 1'b1;
            end
            // vslide1up
            `F6_SLIDEUP: begin
              legal        = is_vx;
              ctrl.vs2_src = vdecode_pkg::VS2_IDX_MINUS_1;
            end
            // vslide1down
            `F6_SLIDEDOWN: begin
              legal        = is_vx;
              ctrl.vs2_src = vdecode_pkg::VS2_IDX_PLUS_1;
            end
            default: legal = 1'b0;
          endcase
        end
        default: legal = 1'b0;
      endcase
    end

    if (!legal) begin
      ctrl.illegal = 1'b1;
      ctrl.wen     = 1'b0;
    end
  end

endmodule

// File: source/velement_counter.sv
// element counter, walks the index range two elements per cycle and owns busy
`timescale 1ns/1ns
`include "vdecode_macros.svh"

module velement_counter (
  input  logic                    CLK,
  input  logic                    nRST,
  input  vdecode_pkg::vctrl_t     ctrl,
  input  vdecode_pkg::csr_state_t csr,
  input  logic                    instr_valid,
  input  logic                    stall,
  input  logic                    flush,
  output vdecode_pkg::elem_pos_t  pos,
  output logic                    busy
);

  logic [`OFFSET_W-1:0] offset_q;
  logic [`OFFSET_W-1:0] cur;
  logic [`XLEN-1:0]     next_idx;
  logic                 accept;
  logic                 processing;
  logic                 done;

  assign accept     = instr_valid & ~busy & ~stall & ~flush;
  assign processing = (accept | busy) & ~stall & ~flush;

  // first pair starts at vstart
  assign cur = accept ? csr.vstart[`OFFSET_W-1:0] : offset_q;

  // end test is done at full width so a large vl still terminates
  assign next_idx = `XLEN'(cur) + `XLEN'(`LANES);
  assign done     = processing & (ctrl.cfg | ctrl.illegal | (next_idx >= csr.vl));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset_q <= '0;
      busy     <= 1'b0;
    end else if (flush) begin
      offset_q <= '0;
      busy     <= 1'b0;
    end else if (processing) begin
      offset_q <= cur + `OFFSET_W'(`LANES);
      busy     <= ~done;
    end
  end

  assign pos.offset = cur;
  assign pos.active = processing;
  assign pos.done   = done;

endmodule

// File: source/voffset_gen.sv
// offset generator, forms vs1, vs2 and vd element offsets for both lanes
`timescale 1ns/1ns
`include "vdecode_macros.svh"

module voffset_gen (
  input  vdecode_pkg::vctrl_t           ctrl,
  input  vdecode_pkg::elem_pos_t        pos,
  input  logic [`XLEN-1:0]              xs1,
  input  logic [`LANES-1:0][`XLEN-1:0]  vs1_data,
  output vdecode_pkg::lane_offs_t       offs
);

  logic [`OFFSET_W-1:0] rs1_off;
  logic [`OFFSET_W-1:0] uimm_off;
  logic [`LANES-1:0][`OFFSET_W-1:0] base;

  // all sums wrap at the offset width
  assign rs1_off  = xs1[`OFFSET_W-1:0];
  assign uimm_off = `OFFSET_W'(ctrl.imm5);

  always_comb begin
    for (int k = 0; k < `LANES; k++) begin
      // lane k normally handles element i+k
      base[k] = pos.offset + `OFFSET_W'(k);

      case (ctrl.vs1_src)
        vdecode_pkg::VS1_ZERO: offs.vs1[k] = '0;
        default:               offs.vs1[k] = base[k];
      endcase

      case (ctrl.vs2_src)
        vdecode_pkg::VS2_IDX_PLUS_RS1:  offs.vs2[k] = base[k] + rs1_off;
        vdecode_pkg::VS2_IDX_PLUS_UIMM: offs.vs2[k] = base[k] + uimm_off;
        vdecode_pkg::VS2_IDX_PLUS_1:    offs.vs2[k] = base[k] + 1'b1;
        vdecode_pkg::VS2_IDX_MINUS_1:   offs.vs2[k] = base[k] - 1'b1;
        // gather index comes from the vs1 element
        vdecode_pkg::VS2_VS1:           offs.vs2[k] = vs1_data[k][`OFFSET_W-1:0];
        vdecode_pkg::VS2_RS1:           offs.vs2[k] = rs1_off;
        vdecode_pkg::VS2_UIMM:          offs.vs2[k] = uimm_off;
        default:                        offs.vs2[k] = base[k];
      endcase

      case (ctrl.vd_src)
        vdecode_pkg::VD_IDX_PLUS_RS1:  offs.vd[k] = base[k] + rs1_off;
        vdecode_pkg::VD_IDX_PLUS_UIMM: offs.vd[k] = base[k] + uimm_off;
        default:                       offs.vd[k] = base[k];
      endcase
    end
  end

endmodule

// File: source/voperand_select.sv
// operand select, builds the register file request and the next execute record
`timescale 1ns/1ns
`include "vdecode_macros.svh"

module voperand_select (
  input  vdecode_pkg::vctrl_t        ctrl,
  input  vdecode_pkg::elem_pos_t     pos,
  input  vdecode_pkg::csr_state_t    csr,
  input  vdecode_pkg::lane_offs_t    offs,
  input  logic [`XLEN-1:0]           xs1,
  input  vdecode_pkg::rf_read_rsp_t  rf_rsp,
  output vdecode_pkg::rf_read_req_t  rf_req,
  output vdecode_pkg::de_t           sel
);

  vdecode_pkg::sew_t sew;
  vdecode_pkg::sew_t sew_wide;
  vdecode_pkg::sew_t sew_narrow;

  assign sew        = vdecode_pkg::sew_t'(csr.vtype[4:3]);
  // wider saturates at 32, narrower at 8
  assign sew_wide   = (sew == vdecode_pkg::SEW8) ? vdecode_pkg::SEW16 : vdecode_pkg::SEW32;
  assign sew_narrow = (sew == vdecode_pkg::SEW32) ? vdecode_pkg::SEW16 : vdecode_pkg::SEW8;

  assign rf_req.vs1     = ctrl.vs1;
  assign rf_req.vs2     = ctrl.vs2;
  assign rf_req.vs3     = ctrl.vd;
  assign rf_req.vs1_off = offs.vs1;
  assign rf_req.vs2_off = offs.vs2;
  assign rf_req.vs3_off = offs.vd;
  // narrowing reads a double-width source
  assign rf_req.vs2_sew = ctrl.narrow ? sew_wide : sew;

  always_comb begin
    sel           = '0;
    sel.active    = pos.active;
    sel.woffset0  = offs.vd[0];
    sel.woffset1  = offs.vd[1];
    sel.vs1_lanes = rf_rsp.vs1_data;
    sel.vs2_lanes = rf_rsp.vs2_data;
    sel.vs3_lanes = rf_rsp.vs3_data;
    sel.xs1       = xs1;
    sel.vd        = ctrl.vd;
    sel.aluop     = ctrl.aluop;
    sel.sew       = sew;
    sel.eew       = ctrl.widen  ? sew_wide :
                    ctrl.narrow ? sew_narrow : sew;
    sel.vl        = csr.vl;
    sel.is_masked = ~ctrl.vm;
    sel.cfg_valid = ctrl.cfg;
    sel.illegal   = ctrl.illegal;

    for (int k = 0; k < `LANES; k++) begin
      // v0 mask and tail limit
      sel.wen[k] = ctrl.wen & (ctrl.vm | rf_rsp.v0_mask[k]) &
                   ((`XLEN'(pos.offset) + `XLEN'(k)) < csr.vl);

      // vslide1down inserts the scalar at element vl
      if (ctrl.vs2_src == vdecode_pkg::VS2_IDX_PLUS_1 && `XLEN'(offs.vs2[k]) == csr.vl) begin
        sel.vs2_lanes[k] = xs1;
      end
    end

    // vslide1up inserts the scalar at element vstart
    if (ctrl.vs2_src == vdecode_pkg::VS2_IDX_MINUS_1 && `XLEN'(pos.offset) == csr.vstart) begin
      sel.vs2_lanes[0] = xs1;
    end
  end

endmodule

// File: source/vdecode_exec_reg.sv
// decode to execute register with immediate and vector config forming
`timescale 1ns/1ns
`include "vdecode_macros.svh"

module vdecode_exec_reg (
  input  logic                   CLK,
  input  logic                   nRST,
  input  vdecode_pkg::de_t       sel,
  input  vdecode_pkg::vctrl_t    ctrl,
  input  vdecode_pkg::elem_pos_t pos,
  input  vdecode_pkg::vinstr_u   instr,
  input  logic [`XLEN-1:0]       xs1,
  input  logic [`XLEN-1:0]       xs2,
  input  logic                   stall,
  input  logic                   flush,
  output vdecode_pkg::de_t       de
);

  vdecode_pkg::de_t de_next;

  always_comb begin
    de_next     = sel;
    de_next.imm = ctrl.imm_signed ? {{(`XLEN-5){ctrl.imm5[4]}}, ctrl.imm5} :
                                    {{(`XLEN-5){1'b0}}, ctrl.imm5};

    // vsetvli carries 11 vtype bits, vsetivli 10, vsetvl takes rs2
    if (!instr.cfg.sel_ivli) begin
      de_next.next_vtype = `XLEN'(instr.cfg.vtypei);
    end else if (instr.cfg.vtypei[10]) begin
      de_next.next_vtype = `XLEN'(instr.cfg.vtypei[9:0]);
    end else begin
      de_next.next_vtype = xs2;
    end

    de_next.next_avl = instr.cfg.sel_ivli ? `XLEN'(instr.cfg.rs1_uimm) : xs1;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      de <= '0;
    end else if (flush) begin
      de <= '0;
    end else if (!stall) begin
      // bubble on idle cycles
      de <= pos.active ? de_next : '0;
    end
  end

endmodule

// File: source/vdecode_top.sv
// vector decode stage top, ties control, counter, offsets, operands and the de register
`timescale 1ns/1ns
`include "vdecode_macros.svh"

module vdecode_top (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vdecode_pkg::vinstr_u      instr,
  input  logic                      instr_valid,
  input  logic                      stall,
  input  logic                      flush,
  input  vdecode_pkg::csr_state_t   csr,
  input  logic [`XLEN-1:0]          xs1,
  input  logic [`XLEN-1:0]          xs2,
  input  vdecode_pkg::rf_read_rsp_t rf_rsp,
  output vdecode_pkg::rf_read_req_t rf_req,
  output logic                      busy,
  output vdecode_pkg::de_t          de
);

  vdecode_pkg::vctrl_t     ctrl;
  vdecode_pkg::elem_pos_t  pos;
  vdecode_pkg::lane_offs_t offs;
  vdecode_pkg::de_t        sel;

  vcontrol_unit u_vcontrol_unit (
    .instr (instr),
    .ctrl  (ctrl)
  );

  velement_counter u_velement_counter (
    .CLK         (CLK),
    .nRST        (nRST),
    .ctrl        (ctrl),
    .csr         (csr),
    .instr_valid (instr_valid),
    .stall       (stall),
    .flush       (flush),
    .pos         (pos),
    .busy        (busy)
  );

  // gather offsets depend on the vs1 read data
  voffset_gen u_voffset_gen (
    .ctrl     (ctrl),
    .pos      (pos),
    .xs1      (xs1),
    .vs1_data (rf_rsp.vs1_data),
    .offs     (offs)
  );

  voperand_select u_voperand_select (
    .ctrl   (ctrl),
    .pos    (pos),
    .csr    (csr),
    .offs   (offs),
    .xs1    (xs1),
    .rf_rsp (rf_rsp),
    .rf_req (rf_req),
    .sel    (sel)
  );

  vdecode_exec_reg u_vdecode_exec_reg (
    .CLK   (CLK),
    .nRST  (nRST),
    .sel   (sel),
    .ctrl  (ctrl),
    .pos   (pos),
    .instr (instr),
    .xs1   (xs1),
    .xs2   (xs2),
    .stall (stall),
    .flush (flush),
    .de    (de)
  );

endmodule

// File: test/vdecode_chk.sv
// decode stage checker, concurrent rules on stall, flush and write enables
`timescale 1ns/1ns

module vdecode_chk (
  input logic             CLK,
  input logic             nRST,
  input logic             stall,
  input logic             flush,
  input logic             busy,
  input vdecode_pkg::de_t de
);

  // a stalled cycle keeps the execute record
  a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    stall && !flush |=> $stable(de))
    else $error("de changed across a stall cycle");

  // flush empties the record and the sequencer
  a_flush_clear: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !de.active && !busy)
    else $error("de.active or busy high after a flush");

  a_bubble_wen: assert property (@(posedge CLK) disable iff (!nRST)
    !de.active |-> de.wen == '0)
    else $error("write enable set in a bubble");

endmodule

bind vdecode_top vdecode_chk u_vdecode_chk (.*);

// File: test/vdecode_tb.sv
// table driven testbench for the vector decode stage with a register file model
`timescale 1ns/1ns
`include "vdecode_macros.svh"

module vdecode_tb;

  // element walking modes of the table rows
  localparam int M_NORM = 0, M_GVV = 1, M_GRS1 = 2, M_GUIMM = 3, M_UPX = 4, M_UPI = 5;
  localparam int M_DNX = 6, M_DNI = 7, M_S1UP = 8, M_S1DN = 9, M_CFG = 10, M_ILL = 11;

  typedef struct {
    string                name;
    int                   mode;
    vdecode_pkg::aluop_t  op;
    int                   wn;
    bit                   sgn;
    logic [31:0]          word;
    logic [`XLEN-1:0]     vtype;
    logic [`XLEN-1:0]     vl;
    logic [`XLEN-1:0]     vstart;
    logic [`XLEN-1:0]     x1;
    logic [`XLEN-1:0]     x2;
    int                   st;
    int                   fl;
  } row_t;

  logic                      CLK;
  logic                      nRST;
  vdecode_pkg::vinstr_u      instr;
  logic                      instr_valid;
  logic                      stall;
  logic                      flush;
  vdecode_pkg::csr_state_t   csr;
  logic [`XLEN-1:0]          xs1;
  logic [`XLEN-1:0]          xs2;
  vdecode_pkg::rf_read_rsp_t rf_rsp;
  vdecode_pkg::rf_read_req_t rf_req;
  logic                      busy;
  vdecode_pkg::de_t          de;

  row_t             rows[$];
  vdecode_pkg::de_t got[$];
  int               seed = 14;

  vdecode_top u_vdecode_top (.*);

  always #20 CLK = ~CLK;

  function automatic logic [`XLEN-1:0] elem(logic [`VREG_W-1:0] r, logic [7:0] e);
    return {19'd0, r, 8'd0} + {24'd0, e};
  endfunction

  // register file answers in the same cycle
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      rf_rsp.vs1_data[k] = elem(rf_req.vs1, rf_req.vs1_off[k]);
      rf_rsp.vs2_data[k] = elem(rf_req.vs2, rf_req.vs2_off[k]);
      rf_rsp.vs3_data[k] = elem(rf_req.vs3, rf_req.vs3_off[k]);
      rf_rsp.v0_mask[k]  = ~rf_req.vs3_off[k][1];
    end
  end

  function automatic logic [31:0] ar(logic [5:0] f6, logic vm, logic [4:0] vs2,
                                     logic [4:0] vs1, logic [2:0] f3, logic [4:0] vd);
    return {f6, vm, vs2, vs1, f3, vd, `OPC_OPV};
  endfunction

  task automatic add_row(string name, int mode, vdecode_pkg::aluop_t op, int wn, bit sgn,
                         logic [31:0] word, logic [31:0] vtype, logic [31:0] vl,
                         logic [31:0] vstart, logic [31:0] x1, logic [31:0] x2,
                         int st, int fl);
    row_t r;
    r = '{name, mode, op, wn, sgn, word, vtype, vl, vstart, x1, x2, st, fl};
    rows.push_back(r);
  endtask

  task automatic fail_stop();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_de_t(string name, vdecode_pkg::de_t exp, vdecode_pkg::de_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_sew_t(string name, vdecode_pkg::sew_t exp, vdecode_pkg::sew_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
      fail_stop();
    end
  endtask

  task automatic check_xlen(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  // 8 to 16, 16 to 32, 32 stays
  function automatic vdecode_pkg::sew_t wider(vdecode_pkg::sew_t s);
    vdecode_pkg::sew_t w;
    case (s)
      vdecode_pkg::SEW8:  w = vdecode_pkg::SEW16;
      vdecode_pkg::SEW16: w = vdecode_pkg::SEW32;
      default:            w = vdecode_pkg::SEW32;
    endcase
    return w;
  endfunction

  // 32 to 16, 16 to 8, 8 stays
  function automatic vdecode_pkg::sew_t narrower(vdecode_pkg::sew_t s);
    vdecode_pkg::sew_t w;
    case (s)
      vdecode_pkg::SEW32: w = vdecode_pkg::SEW16;
      vdecode_pkg::SEW16: w = vdecode_pkg::SEW8;
      default:            w = vdecode_pkg::SEW8;
    endcase
    return w;
  endfunction

  // expected record for the pair that starts at element i
  function automatic vdecode_pkg::de_t expect_rec(row_t r, logic [7:0] i);
    vdecode_pkg::de_t e;
    logic [7:0]       o1;
    logic [7:0]       o2;
    logic [7:0]       od;
    logic [7:0]       ix;
    logic [4:0]       imm5;
    logic [2:0]       f3;
    bit               vm;
    bit               wr;
    imm5 = r.word[19:15];
    f3   = r.word[14:12];
    vm   = (r.mode == M_CFG) ? 1'b1 : r.word[25];
    wr   = (r.mode != M_CFG) && (r.mode != M_ILL);
    e    = '0;
    e.active = 1'b1;
    for (int k = 0; k < 2; k++) begin
      ix = i + 8'(k);
      o1 = (f3 == `F3_IVV || f3 == `F3_MVV) ? ix : 8'd0;
      od = ix;
      case (r.mode)
        M_GVV:   o2 = 8'(elem(r.word[19:15], o1));
        M_GRS1:  o2 = r.x1[7:0];
        M_GUIMM: o2 = 8'(imm5);
        M_DNX:   o2 = ix + r.x1[7:0];
        M_DNI:   o2 = ix + 8'(imm5);
        M_S1UP:  o2 = ix - 8'd1;
        M_S1DN:  o2 = ix + 8'd1;
        default: o2 = ix;
      endcase
      if (r.mode == M_UPX) od = ix + r.x1[7:0];
      if (r.mode == M_UPI) od = ix + 8'(imm5);
      e.vs1_lanes[k] = elem(r.word[19:15], o1);
      e.vs2_lanes[k] = elem(r.word[24:20], o2);
      e.vs3_lanes[k] = elem(r.word[11:7], od);
      if (r.mode == M_S1DN && 32'(o2) == r.vl) e.vs2_lanes[k] = r.x1;
      if (r.mode == M_S1UP && k == 0 && 32'(i) == r.vstart) e.vs2_lanes[k] = r.x1;
      e.wen[k] = wr && (vm || !od[1]) && ((32'(i) + k) < r.vl);
      if (k == 0) e.woffset0 = od;
      else e.woffset1 = od;
    end
    e.imm       = r.sgn ? {{27{imm5[4]}}, imm5} : {27'd0, imm5};
    e.xs1       = r.x1;
    e.vd        = r.word[11:7];
    e.aluop     = r.op;
    e.sew       = vdecode_pkg::sew_t'(r.vtype[4:3]);
    e.eew       = (r.wn == 1) ? wider(e.sew) :
                  (r.wn == 2) ? narrower(e.sew) : e.sew;
    e.vl        = r.vl;
    e.is_masked = !vm;
    e.cfg_valid = (r.mode == M_CFG);
    e.illegal   = (r.mode == M_ILL);
    if (!r.word[31]) e.next_vtype = 32'(r.word[30:20]);
    else if (r.word[30]) e.next_vtype = 32'(r.word[29:20]);
    else e.next_vtype = r.x2;
    e.next_avl  = r.word[31] ? 32'(imm5) : r.x1;
    return e;
  endfunction

  task automatic run_row(row_t r);
    vdecode_pkg::sew_t s;
    int  c;
    int  n;
    bit  fin;
    got.delete();
    instr = r.word;
    csr   = '{r.vtype, r.vl, r.vstart};
    xs1   = r.x1;
    xs2   = r.x2;
    instr_valid = 1'b1;
    #5;
    s = vdecode_pkg::sew_t'(r.vtype[4:3]);
    check_sew_t({r.name, " vs2_sew"}, (r.wn == 2) ? wider(s) : s, rf_req.vs2_sew);
    c   = 0;
    fin = 0;
    while (!fin) begin
      if (c > 64) begin
        $display("timeout waiting for busy low in %s", r.name);
        fail_stop();
      end
      stall = (c == r.st);
      flush = (c == r.fl);
      @(posedge CLK);
      #1;
      // a stalled edge repeats the held record
      if (de.active && c != r.st) got.push_back(de);
      if (c == r.fl) begin
        check_xlen({r.name, " busy after flush"}, 0, busy);
        check_de_t({r.name, " bubble after flush"}, '0, de);
        fin = 1;
      end else if (c != r.st && !busy) begin
        fin = 1;
      end
      #1;
      instr_valid = 1'b0;
      stall = 1'b0;
      flush = 1'b0;
      c++;
    end
    if (r.mode == M_CFG || r.mode == M_ILL || r.vstart >= r.vl) n = 1;
    else n = (r.vl - r.vstart + 1) / 2;
    if (r.fl >= 0 && r.fl < n) n = r.fl;
    check_xlen({r.name, " records"}, n, got.size());
    for (int j = 0; j < n; j++) begin
      check_de_t($sformatf("%s pair %0d", r.name, j),
                 expect_rec(r, r.vstart[7:0] + 8'(2 * j)), got[j]);
    end
  endtask

  initial begin
    CLK = 0;
    nRST = 0;
    instr = '0;
    instr_valid = 0;
    stall = 0;
    flush = 0;
    csr = '0;
    xs1 = '0;
    xs2 = '0;
    add_row("vsetvli", M_CFG, vdecode_pkg::ALU_MOVE, 0, 0,
            {1'b0, 11'h0d1, 5'd3, `F3_CFG, 5'd4, `OPC_OPV}, 8, 4, 0, 17, 99, -1, -1);
    add_row("vsetivli", M_CFG, vdecode_pkg::ALU_MOVE, 0, 0,
            {2'b11, 10'h0c8, 5'd9, `F3_CFG, 5'd6, `OPC_OPV}, 0, 4, 0, 17, 99, -1, -1);
    add_row("vadd_vv", M_NORM, vdecode_pkg::ALU_ADD, 0, 0,
            ar(`F6_ADD, 0, 2, 3, `F3_IVV, 1), 0, 7, 0, 0, 0, -1, -1);
    add_row("vadd_vx", M_NORM, vdecode_pkg::ALU_ADD, 0, 0,
            ar(`F6_ADD, 1, 2, 0, `F3_IVX, 4), 8, 7, 0, 5, 0, -1, -1);
    add_row("vadd_vi", M_NORM, vdecode_pkg::ALU_ADD, 0, 1,
            ar(`F6_ADD, 1, 2, 5'b10110, `F3_IVI, 4), 16, 7, 0, 0, 0, -1, -1);
    add_row("vsub_vv", M_NORM, vdecode_pkg::ALU_SUB, 0, 0,
            ar(`F6_SUB, 1, 5, 6, `F3_IVV, 7), 0, 5, 0, 0, 0, -1, -1);
    add_row("vadd_past_vl", M_NORM, vdecode_pkg::ALU_ADD, 0, 0,
            ar(`F6_ADD, 1, 2, 3, `F3_IVV, 1), 0, 3, 4, 0, 0, -1, -1);
    add_row("vrgather_vv", M_GVV, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_RGATHER, 1, 2, 3, `F3_IVV, 1), 0, 6, 0, 0, 0, -1, -1);
    add_row("vrgather_vx", M_GRS1, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_RGATHER, 1, 2, 0, `F3_IVX, 1), 0, 6, 0, 3, 0, -1, -1);
    add_row("vrgather_vi", M_GUIMM, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_RGATHER, 1, 2, 6, `F3_IVI, 1), 0, 6, 0, 0, 0, -1, -1);
    add_row("vslideup_vx", M_UPX, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_SLIDEUP, 1, 2, 0, `F3_IVX, 8), 0, 6, 0, 2, 0, -1, -1);
    add_row("vslideup_vi", M_UPI, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_SLIDEUP, 1, 2, 3, `F3_IVI, 8), 0, 6, 0, 0, 0, -1, -1);
    add_row("vslidedown_vx", M_DNX, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_SLIDEDOWN, 1, 2, 0, `F3_IVX, 8), 0, 6, 0, 2, 0, -1, -1);
    add_row("vslidedown_vi", M_DNI, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_SLIDEDOWN, 1, 2, 3, `F3_IVI, 8), 0, 6, 0, 0, 0, -1, -1);
    add_row("vslide1up", M_S1UP, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_SLIDEUP, 1, 2, 0, `F3_MVX, 8), 0, 6, 1, 32'hdeadbeef, 0, -1, -1);
    add_row("vslide1down", M_S1DN, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(`F6_SLIDEDOWN, 1, 2, 0, `F3_MVX, 8), 0, 6, 0, 32'hcafe0001, 0, -1, -1);
    add_row("vwaddu_mvv_8", M_NORM, vdecode_pkg::ALU_ADD, 1, 0,
            ar(`F6_WADDU, 1, 2, 3, `F3_MVV, 4), 0, 4, 0, 0, 0, -1, -1);
    add_row("vwaddu_mvx_16", M_NORM, vdecode_pkg::ALU_ADD, 1, 0,
            ar(`F6_WADDU, 1, 2, 0, `F3_MVX, 4), 8, 4, 0, 7, 0, -1, -1);
    add_row("vwaddu_mvx_32", M_NORM, vdecode_pkg::ALU_ADD, 1, 0,
            ar(`F6_WADDU, 1, 2, 0, `F3_MVX, 4), 16, 4, 0, 7, 0, -1, -1);
    add_row("vnsrl_vv_32", M_NORM, vdecode_pkg::ALU_SRL, 2, 0,
            ar(`F6_NSRL, 1, 2, 3, `F3_IVV, 4), 16, 4, 0, 0, 0, -1, -1);
    add_row("vnsrl_vx_16", M_NORM, vdecode_pkg::ALU_SRL, 2, 0,
            ar(`F6_NSRL, 1, 2, 0, `F3_IVX, 4), 8, 4, 0, 1, 0, -1, -1);
    add_row("vnsrl_vi_8", M_NORM, vdecode_pkg::ALU_SRL, 2, 0,
            ar(`F6_NSRL, 1, 2, 2, `F3_IVI, 4), 0, 4, 0, 0, 0, -1, -1);
    add_row("vadd_stall", M_NORM, vdecode_pkg::ALU_ADD, 0, 0,
            ar(`F6_ADD, 0, 2, 3, `F3_IVV, 1), 0, 7, 0, 0, 0, 2, -1);
    add_row("vadd_flush", M_NORM, vdecode_pkg::ALU_ADD, 0, 0,
            ar(`F6_ADD, 1, 2, 3, `F3_IVV, 1), 0, 9, 0, 0, 0, -1, 2);
    add_row("illegal", M_ILL, vdecode_pkg::ALU_MOVE, 0, 0,
            ar(6'b111111, 1, 2, 3, `F3_IVV, 1), 0, 7, 0, 0, 0, -1, -1);
    for (int j = 0; j < 3; j++) begin
      add_row($sformatf("vadd_vx_rand%0d", j), M_NORM, vdecode_pkg::ALU_ADD, 0, 0,
              ar(`F6_ADD, 1, 2, 0, `F3_IVX, 4), 0, 9, 32'($unsigned($random(seed)) % 6),
              $random(seed), 0, -1, -1);
    end
    repeat (3) @(posedge CLK);
    #2;
    nRST = 1;
    foreach (rows[j]) begin
      run_row(rows[j]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: list.f
+incdir+source
source/vdecode_pkg.sv
source/vcontrol_unit.sv
source/velement_counter.sv
source/voffset_gen.sv
source/voperand_select.sv
source/vdecode_exec_reg.sv
source/vdecode_top.sv
test/vdecode_chk.sv
test/vdecode_tb.sv
